/* rtl/aes_pkg.sv */
// AES-128 shared definitions.
// Widths, register map, core FSM states and the GF(2^8) byte
// functions used by the round logic and the key schedule.
`default_nettype none

package aes_pkg;

    localparam int BLOCK_W = 128;
    localparam int WORD_W  = 32;

    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [7:0]         byte_t;
    typedef logic [3:0]         round_cnt_t;

    localparam round_cnt_t NUM_ROUNDS = 4'd10;

    typedef enum logic {
        CORE_IDLE = 1'b0,
        CORE_RUN  = 1'b1
    } core_state_e;

    // word addresses on the bus.
    typedef enum logic [3:0] {
        REG_KEY0    = 4'd0,
        REG_KEY1    = 4'd1,
        REG_KEY2    = 4'd2,
        REG_KEY3    = 4'd3,
        REG_TEXT0   = 4'd4,
        REG_TEXT1   = 4'd5,
        REG_TEXT2   = 4'd6,
        REG_TEXT3   = 4'd7,
        REG_CTRL    = 4'd8,
        REG_STATUS  = 4'd9,
        REG_RESULT0 = 4'd12,
        REG_RESULT1 = 4'd13,
        REG_RESULT2 = 4'd14,
        REG_RESULT3 = 4'd15
    } reg_addr_e;

    // multiply by x, reduced by x^8 + x^4 + x^3 + x + 1.
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add product in GF(2^8).
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = xtime(x);
        end
        return p;
    endfunction

    function automatic byte_t sbox(byte_t b);
        byte_t inv;
        inv = 8'h01;
        // b^254 is the inverse, and maps 0 to 0.
        for (int i = 7; i >= 0; i--)
        begin
            inv = gf_mul(inv, inv);
            if (i != 0)
                inv = gf_mul(inv, b);
        end
        // affine map.
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

endpackage

`default_nettype wire

/* rtl/aes_key_sched.sv */
// AES-128 key schedule, computed one round ahead on the fly.
// The next round key is shown combinationally so the round that
// runs on the same edge consumes it.
`timescale 1ns/10ps
`default_nettype none

module aes_key_sched
(
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire logic           load,
    input  wire logic           step,
    input  wire aes_pkg::block_t key,
    output aes_pkg::block_t      round_key
);

    aes_pkg::block_t key_q;
    aes_pkg::byte_t  rcon_q;
    aes_pkg::word_t  w0, w1, w2, w3;
    aes_pkg::word_t  t;
    aes_pkg::word_t  n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = key_q;

    // rotword then subword, rcon in the top byte.
    assign t = {aes_pkg::sbox(w3[23:16]) ^ rcon_q, aes_pkg::sbox(w3[15:8]),
                aes_pkg::sbox(w3[7:0]), aes_pkg::sbox(w3[31:24])};

    assign n0 = w0 ^ t;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rcon_q <= 8'h00;
        else if (load)
            rcon_q <= 8'h01;
        else if (step)
            rcon_q <= aes_pkg::xtime(rcon_q);
    end

    always_ff @(posedge clk)
    begin
        if (load)
            key_q <= key;
        else if (step)
            key_q <= round_key;
    end

endmodule

`default_nettype wire

/* rtl/aes_round.sv */
// One AES encryption round, purely combinational.
// SubBytes, ShiftRows, MixColumns unless last, then AddRoundKey.
`timescale 1ns/10ps
`default_nettype none

module aes_round
(
    input  wire aes_pkg::block_t state_in,
    input  wire aes_pkg::block_t round_key,
    input  wire logic            last,
    output aes_pkg::block_t      state_out
);

    aes_pkg::byte_t  sb [16];
    aes_pkg::byte_t  sr [16];
    aes_pkg::byte_t  mc [16];
    aes_pkg::block_t mixed;

    // byte i sits at row i%4, column i/4.
    always_comb
    begin
        for (int i = 0; i < 16; i++)
            sb[i] = aes_pkg::sbox(state_in[127 - 8*i -: 8]);
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                sr[4*c + r] = sb[4*((c + r) % 4) + r];
        end
    end

    // column mix written as a ^ t ^ 2(a ^ next).
    always_comb
    begin
        aes_pkg::byte_t t;
        for (int c = 0; c < 4; c++)
        begin
            t = sr[4*c] ^ sr[4*c+1] ^ sr[4*c+2] ^ sr[4*c+3];
            for (int r = 0; r < 4; r++)
                mc[4*c + r] = sr[4*c + r] ^ t
                            ^ aes_pkg::xtime(sr[4*c + r] ^ sr[4*c + (r + 1) % 4]);
        end
    end

    always_comb
    begin
        for (int i = 0; i < 16; i++)
            mixed[127 - 8*i -: 8] = last ? sr[i] : mc[i];
    end

    assign state_out = mixed ^ round_key;

endmodule

`default_nettype wire

/* rtl/aes_core.sv */
// Iterative AES-128 encryption core, one round per clock.
// Loads text xor key on start, runs ten rounds, pulses done.
`timescale 1ns/10ps
`default_nettype none

module aes_core
(
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            start,
    input  wire aes_pkg::block_t key,
    input  wire aes_pkg::block_t text,
    output logic                 busy,
    output logic                 done,
    output aes_pkg::block_t      result
);

    aes_pkg::core_state_e fsm_q;
    aes_pkg::round_cnt_t  cnt_q;
    aes_pkg::block_t      state_q;
    aes_pkg::block_t      round_key;
    aes_pkg::block_t      round_out;
    logic                 load;
    logic                 step;
    logic                 last;

    assign load = (fsm_q == aes_pkg::CORE_IDLE) && start;
    // no round on the cycle done is high.
    assign step = (fsm_q == aes_pkg::CORE_RUN) && !done;
    assign last = (cnt_q == aes_pkg::NUM_ROUNDS);

    assign busy   = (fsm_q == aes_pkg::CORE_RUN);
    assign result = state_q;

    aes_key_sched u_key
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .step      (step),
        .key       (key),
        .round_key (round_key)
    );

    aes_round u_round
    (
        .state_in  (state_q),
        .round_key (round_key),
        .last      (last),
        .state_out (round_out)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fsm_q <= aes_pkg::CORE_IDLE;
            cnt_q <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (fsm_q)
                aes_pkg::CORE_IDLE:
                    if (start)
                    begin
                        fsm_q <= aes_pkg::CORE_RUN;
                        cnt_q <= 4'd1;
                    end
                aes_pkg::CORE_RUN:
                    if (done)
                    begin
                        fsm_q <= aes_pkg::CORE_IDLE;
                        cnt_q <= '0;
                    end
                    else if (last)
                        done <= 1'b1;
                    else
                        cnt_q <= cnt_q + 4'd1;
                default:
                    fsm_q <= aes_pkg::CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            state_q <= text ^ key;
        else if (step)
            state_q <= round_out;
    end

    // the register block must hold start back while a block is in flight.
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy);

    a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
        cnt_q <= aes_pkg::NUM_ROUNDS);

endmodule

`default_nettype wire

/* rtl/aes_wb_regs.sv */
// Wishbone classic slave register block for the AES core.
// Holds key, text, result and status, and issues the start pulse.
// Single-cycle registered ack, no stalls.
`timescale 1ns/10ps
`default_nettype none

module aes_wb_regs
#(
    parameter int ADDR_W = 4
)
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire logic [ADDR_W-1:0] wb_adr,
    input  wire aes_pkg::word_t    wb_dat_i,
    output aes_pkg::word_t         wb_dat_o,
    output logic                   wb_ack,
    output logic                   start,
    output aes_pkg::block_t        key,
    output aes_pkg::block_t        text,
    input  wire logic              busy,
    input  wire logic              done,
    input  wire aes_pkg::block_t   result
);

    aes_pkg::word_t    key_q    [4];
    aes_pkg::word_t    text_q   [4];
    aes_pkg::word_t    result_q [4];
    logic              done_flag;
    logic              pending;
    logic              hit;
    logic              start_req;
    aes_pkg::reg_addr_e adr;
    aes_pkg::word_t    rd_data;

    assign pending = wb_cyc && wb_stb && !wb_ack;
    // upper address bits must be clear.
    assign hit     = ((wb_adr >> 4) == '0);
    assign adr     = aes_pkg::reg_addr_e'(wb_adr[3:0]);

    assign start_req = pending && wb_we && hit && (adr == aes_pkg::REG_CTRL)
                     && wb_dat_i[0] && !busy;

    assign key  = {key_q[0], key_q[1], key_q[2], key_q[3]};
    assign text = {text_q[0], text_q[1], text_q[2], text_q[3]};

    always_comb
    begin
        rd_data = '0;
        if (hit)
        begin
            case (adr)
                aes_pkg::REG_KEY0, aes_pkg::REG_KEY1,
                aes_pkg::REG_KEY2, aes_pkg::REG_KEY3:
                    rd_data = key_q[wb_adr[1:0]];
                aes_pkg::REG_TEXT0, aes_pkg::REG_TEXT1,
                aes_pkg::REG_TEXT2, aes_pkg::REG_TEXT3:
                    rd_data = text_q[wb_adr[1:0]];
                aes_pkg::REG_STATUS:
                    rd_data = {{(aes_pkg::WORD_W-2){1'b0}}, done_flag, busy};
                aes_pkg::REG_RESULT0, aes_pkg::REG_RESULT1,
                aes_pkg::REG_RESULT2, aes_pkg::REG_RESULT3:
                    rd_data = result_q[wb_adr[1:0]];
                default:
                    rd_data = '0;
            endcase
        end
    end

    // bus side: ack, read data, start and the writable registers.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            start    <= 1'b0;
            for (int i = 0; i < 4; i++)
            begin
                key_q[i]  <= '0;
                text_q[i] <= '0;
            end
        end
        else
        begin
            wb_ack   <= pending;
            wb_dat_o <= (pending && !wb_we) ? rd_data : '0;
            start    <= start_req;
            if (pending && wb_we && hit && !adr[3])
            begin
                if (adr[2])
                    text_q[wb_adr[1:0]] <= wb_dat_i;
                else
                    key_q[wb_adr[1:0]] <= wb_dat_i;
            end
        end
    end

    // core side: capture the ciphertext on done.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done_flag <= 1'b0;
            for (int i = 0; i < 4; i++)
                result_q[i] <= '0;
        end
        else if (done)
        begin
            done_flag <= 1'b1;
            for (int i = 0; i < 4; i++)
                result_q[i] <= result[127 - 32*i -: 32];
        end
        else if (start_req)
            done_flag <= 1'b0;
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* rtl/aes_wb_top.sv */
// AES-128 encryption engine with a Wishbone classic slave port.
// Joins the register block to the iterative core.
`timescale 1ns/10ps
`default_nettype none

module aes_wb_top
#(
    parameter int ADDR_W = 4
)
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire logic [ADDR_W-1:0] wb_adr,
    input  wire aes_pkg::word_t    wb_dat_i,
    output aes_pkg::word_t         wb_dat_o,
    output logic                   wb_ack
);

    logic            start;
    logic            busy;
    logic            done;
    aes_pkg::block_t key;
    aes_pkg::block_t text;
    aes_pkg::block_t result;

    aes_wb_regs #(
        .ADDR_W (ADDR_W)
    ) u_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .start    (start),
        .key      (key),
        .text     (text),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    aes_core u_core
    (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .key    (key),
        .text   (text),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

endmodule

`default_nettype wire

/* sim/tb_aes.sv */
// Testbench for the AES-128 Wishbone engine.
// Reads key, plaintext and ciphertext vectors from a pattern file,
// drives Wishbone accesses and checks registers and results.
`timescale 1ns/10ps
`default_nettype none

module tb_aes;

    logic           clk;
    logic           arst_n;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic [3:0]     wb_adr;
    aes_pkg::word_t wb_dat_i;
    aes_pkg::word_t wb_dat_o;
    logic           wb_ack;

    aes_pkg::block_t key_list  [$];
    aes_pkg::block_t text_list [$];
    aes_pkg::block_t ct_list   [$];
    integer          seed;
    int              errors;
    int              checks;
    bit              loaded;
    bit              quick;

    aes_wb_top #(
        .ADDR_W (4)
    ) u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string name, input aes_pkg::word_t got,
                              input aes_pkg::word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // one classic bus cycle driven on the rising edge and sampled on the falling edge.
    task automatic bus_access(input logic we, input logic [3:0] adr,
                              input aes_pkg::word_t wdata, output aes_pkg::word_t rdata);
        int gap;
        int waited;
        gap = quick ? 0 : {$random(seed)} % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_ack && waited < 8);
        assert (wb_ack)
        else
        begin
            errors++;
            $display("ERROR at %0t: no wb_ack for access to address %0d", $time, adr);
        end
        assert (!wb_ack || waited == 2)
        else
        begin
            errors++;
            $display("FAIL %0t: wb_ack came %0d cycles after wb_stb, expected 1",
                     $time, waited - 1);
        end
        rdata = wb_dat_o;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        assert (!wb_ack)
        else
        begin
            errors++;
            $display("FAIL %0t: wb_ack high for more than one cycle", $time);
        end
    endtask

    task automatic write_reg(input logic [3:0] adr, input aes_pkg::word_t data);
        aes_pkg::word_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_check(input logic [3:0] adr, input aes_pkg::word_t exp,
                              input string name);
        aes_pkg::word_t got;
        bus_access(1'b0, adr, '0, got);
        check_word(name, got, exp);
    endtask

    // word 0 is the most significant.
    task automatic load_block(input logic [3:0] base, input aes_pkg::block_t value);
        for (int i = 0; i < 4; i++)
            write_reg(base + 4'(i), value[127 - 32*i -: 32]);
    endtask

    task automatic check_result(input aes_pkg::block_t exp);
        for (int i = 0; i < 4; i++)
            read_check(aes_pkg::REG_RESULT0 + 4'(i), exp[127 - 32*i -: 32],
                       $sformatf("RESULT%0d", i));
    endtask

    // poll until done is set and busy is clear.
    task automatic wait_done();
        int             polls;
        aes_pkg::word_t status;
        polls = 0;
        do
        begin
            bus_access(1'b0, aes_pkg::REG_STATUS, '0, status);
            polls++;
        end
        while (status != 32'h2 && polls < 40);
        assert (status == 32'h2)
        else
        begin
            errors++;
            $display("ERROR at %0t: done not seen in STATUS after %0d polls", $time, polls);
        end
    endtask

    // budget covers register tests, the busy-start run and every pattern.
    initial
    begin
        wait (loaded);
        repeat (key_list.size() * 160 + 800) @(posedge clk);
        $display("ERROR: timeout, the test sequence did not finish in time");
        $display("summary: %0d checks, %0d errors before timeout", checks, errors);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        int              fd;
        int              n;
        string           line;
        aes_pkg::block_t k;
        aes_pkg::block_t p;
        aes_pkg::block_t c;
        aes_pkg::word_t  data [8];
        seed     = 18;
        errors   = 0;
        checks   = 0;
        loaded   = 1'b0;
        quick    = 1'b0;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;

        fd = $fopen("sim/aes_patterns.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("ERROR: cannot open sim/aes_patterns.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%h %h %h", k, p, c);
                    if (n == 3)
                    begin
                        key_list.push_back(k);
                        text_list.push_back(p);
                        ct_list.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // everything reads zero out of reset.
        for (int a = 0; a < 16; a++)
            read_check(4'(a), '0, $sformatf("register %0d after reset", a));

        for (int a = 0; a < 8; a++)
        begin
            data[a] = $random(seed);
            write_reg(4'(a), data[a]);
        end
        for (int a = 0; a < 8; a++)
            read_check(4'(a), data[a],
                       (a < 4) ? $sformatf("KEY%0d", a) : $sformatf("TEXT%0d", a - 4));
        write_reg(4'd10, 32'hffffffff);
        read_check(4'd10, '0, "unmapped register 10");
        read_check(4'd11, '0, "unmapped register 11");

        for (int i = 0; i < key_list.size(); i++)
        begin
            load_block(aes_pkg::REG_KEY0, key_list[i]);
            if (i > 0 && text_list[i] == text_list[i-1])
            begin
                // only the key changes, so the old ciphertext stays until the new done.
                check_result(ct_list[i-1]);
                quick = 1'b1;
                write_reg(aes_pkg::REG_CTRL, 32'h1);
                read_check(aes_pkg::REG_RESULT0, ct_list[i-1][127:96], "RESULT0 while busy");
                quick = 1'b0;
            end
            else
            begin
                load_block(aes_pkg::REG_TEXT0, text_list[i]);
                write_reg(aes_pkg::REG_CTRL, 32'h1);
            end
            wait_done();
            check_result(ct_list[i]);
        end

        // second start lands while the first block is in flight.
        if (key_list.size() > 0)
        begin
            load_block(aes_pkg::REG_KEY0, key_list[0]);
            load_block(aes_pkg::REG_TEXT0, text_list[0]);
            quick = 1'b1;
            write_reg(aes_pkg::REG_CTRL, 32'h1);
            write_reg(aes_pkg::REG_TEXT0, ~text_list[0][127:96]);
            write_reg(aes_pkg::REG_CTRL, 32'h1);
            read_check(aes_pkg::REG_STATUS, 32'h1, "STATUS while busy");
            quick = 1'b0;
            wait_done();
            check_result(ct_list[0]);
            read_check(aes_pkg::REG_STATUS, 32'h2, "STATUS after done");
        end
        else
        begin
            errors++;
            $display("ERROR: no test vectors were read from the pattern file");
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/aes_patterns.txt */
# key plaintext expected_ciphertext
# each field is 128-bit hex, byte 0 first as in FIPS-197
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e

/* src.f */
rtl/aes_pkg.sv
rtl/aes_key_sched.sv
rtl/aes_round.sv
rtl/aes_core.sv
rtl/aes_wb_regs.sv
rtl/aes_wb_top.sv
sim/tb_aes.sv

/* run_sim.sh */
#!/bin/sh
# build and run the AES testbench with Verilator, result decided from sim.log
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_aes -o tb_aes \
    && ./obj_dir/tb_aes > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Everything OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
